/* rtl/glue_pkg.sv */
`default_nettype none

package glue_pkg;

    // OSD status word and crop settings
    typedef logic [63:0]        status_t;
    typedef logic [11:0]        crop_size_t;
    typedef logic signed [4:0]  crop_off_t;

    // Mouse event fields and pointer state
    typedef logic signed [8:0]  mouse_delta_t;
    typedef logic signed [15:0] mouse_pos_t;
    typedef logic [2:0]         mouse_btn_t;
    typedef logic [2:0]         credit_t;

    // Byte shown on target_info
    typedef enum logic [3:0] {
        PROBE_X_LO    = 4'd0,
        PROBE_X_HI    = 4'd1,
        PROBE_Y_LO    = 4'd2,
        PROBE_Y_HI    = 4'd3,
        PROBE_BTN     = 4'd4,
        PROBE_CROP    = 4'd5,
        PROBE_SIZE_LO = 4'd6,
        PROBE_SIZE_HI = 4'd7
    } probe_sel_e;

    // HDMI mode that tolerates vertical crop
    localparam int CROP_HDMI_W = 1920;
    localparam int CROP_HDMI_H = 1080;
    localparam int CROP_LINES  = 216;

    // vcopt values from VCOPT_SPLIT upward move the picture up
    localparam int VCOPT_SPLIT = 6;
    localparam int VCOPT_WRAP  = 24;

    // Event buffer depth, also the decoder's starting credit
    localparam int MOUSE_DEPTH = 4;
    localparam int MOUSE_PTR_W = $clog2(MOUSE_DEPTH);

    // Status word fields
    localparam int ST_FX_LO    = 3;
    localparam int ST_FX_HI    = 5;
    localparam int ST_CROP_EN  = 41;
    localparam int ST_VCOPT_LO = 42;
    localparam int ST_SCALE_LO = 46;

    // Toggles once per new mouse packet
    localparam int PKT_STROBE  = 24;

endpackage

`default_nettype wire

/* rtl/crop_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module crop_ctrl (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire glue_pkg::status_t    status,
    input  wire [11:0]                hdmi_width,
    input  wire [11:0]                hdmi_height,
    input  wire                       force_scan2x,
    input  wire                       direct_video,
    input  wire [1:0]                 rotate,
    output logic                      crop_ok,
    output glue_pkg::crop_off_t       crop_off,
    output glue_pkg::crop_size_t      crop_size
);
    import glue_pkg::*;

    logic [2:0] fx_level;
    logic [1:0] scale;
    logic [3:0] vcopt;
    logic [4:0] vcopt_x2;
    logic       crop_en;
    logic       mode_ok;

    assign fx_level = status[ST_FX_HI:ST_FX_LO];
    assign scale    = status[ST_SCALE_LO +: 2];
    assign vcopt    = status[ST_VCOPT_LO +: 4];
    assign crop_en  = status[ST_CROP_EN];

    // Offset is in steps of two lines
    assign vcopt_x2 = {vcopt, 1'b0};

    // Only a plain 1080p output with no scan FX or rotation can crop
    assign mode_ok = (hdmi_width == 12'(CROP_HDMI_W)) &&
                     (hdmi_height == 12'(CROP_HDMI_H)) &&
                     (fx_level == 3'd0) &&
                     !force_scan2x &&
                     (scale == 2'd0) &&
                     !direct_video &&
                     !rotate[0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            crop_ok   <= 1'b0;
            crop_off  <= '0;
            crop_size <= '0;
        end else begin
            crop_ok <= mode_ok;
            if (vcopt < 4'(VCOPT_SPLIT)) begin
                crop_off <= vcopt_x2;
            end else begin
                // Wraps into the negative half of the 5-bit range
                crop_off <= vcopt_x2 - 5'(VCOPT_WRAP);
            end
            // Uses last cycle's crop_ok, so one cycle behind
            crop_size <= (crop_ok && crop_en) ? crop_size_t'(CROP_LINES) : '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/mouse_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mouse_decoder (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire [24:0]                ps2_mouse,
    input  wire                       credit_return,
    output logic                      ev_valid,
    output glue_pkg::mouse_delta_t    ev_dx,
    output glue_pkg::mouse_delta_t    ev_dy,
    output glue_pkg::mouse_btn_t      ev_btn,
    output logic                      mouse_overrun
);
    import glue_pkg::*;

    logic       strobe_l;
    logic       new_pkt;
    logic       send;
    logic [7:0] pkt_flags;
    credit_t    credits;

    assign new_pkt   = ps2_mouse[PKT_STROBE] ^ strobe_l;
    assign send      = new_pkt && (credits != '0);
    assign pkt_flags = ps2_mouse[7:0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            // Track the strobe so no packet is seen coming out of reset
            strobe_l      <= ps2_mouse[PKT_STROBE];
            ev_valid      <= 1'b0;
            mouse_overrun <= 1'b0;
            credits       <= credit_t'(MOUSE_DEPTH);
        end else begin
            strobe_l <= ps2_mouse[PKT_STROBE];
            ev_valid <= send;
            if (new_pkt && !send) begin
                mouse_overrun <= 1'b1;
            end
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Sign bits live in the flag byte
    always_ff @(posedge clk_sys) begin
        if (send) begin
            ev_dx  <= {pkt_flags[4], ps2_mouse[15:8]};
            ev_dy  <= {pkt_flags[5], ps2_mouse[23:16]};
            ev_btn <= pkt_flags[2:0];
        end
    end

    // The buffer must never hand back more credit than was issued
    assert property (@(posedge clk_sys) disable iff (reset)
        credits <= credit_t'(MOUSE_DEPTH))
        else $error("credit count above MOUSE_DEPTH");

endmodule

`default_nettype wire

/* rtl/mouse_event_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module mouse_event_buffer (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire                         ev_valid,
    input  wire glue_pkg::mouse_delta_t ev_dx,
    input  wire glue_pkg::mouse_delta_t ev_dy,
    input  wire glue_pkg::mouse_btn_t   ev_btn,
    input  wire                         ev_pop,
    output logic                        ev_avail,
    output glue_pkg::mouse_delta_t      head_dx,
    output glue_pkg::mouse_delta_t      head_dy,
    output glue_pkg::mouse_btn_t        head_btn,
    output logic                        credit_return
);
    import glue_pkg::*;

    mouse_delta_t           mem_dx  [MOUSE_DEPTH];
    mouse_delta_t           mem_dy  [MOUSE_DEPTH];
    mouse_btn_t             mem_btn [MOUSE_DEPTH];
    logic [MOUSE_PTR_W-1:0] wr_ptr;
    logic [MOUSE_PTR_W-1:0] rd_ptr;
    credit_t                fill;
    logic                   full;

    assign full     = (fill == credit_t'(MOUSE_DEPTH));
    assign ev_avail = (fill != '0);

    // Head of queue, read straight from the array
    assign head_dx  = mem_dx[rd_ptr];
    assign head_dy  = mem_dy[rd_ptr];
    assign head_btn = mem_btn[rd_ptr];

    // Each slot freed goes straight back to the decoder
    assign credit_return = ev_pop;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (ev_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ev_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({ev_valid, ev_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (ev_valid) begin
            mem_dx[wr_ptr]  <= ev_dx;
            mem_dy[wr_ptr]  <= ev_dy;
            mem_btn[wr_ptr] <= ev_btn;
        end
    end

    // Credit accounting in the decoder keeps pushes within depth
    assert property (@(posedge clk_sys) disable iff (reset) ev_valid |-> !full)
        else $error("push into full mouse event FIFO");

    // Tracker only pops what is there
    assert property (@(posedge clk_sys) disable iff (reset) ev_pop |-> ev_avail)
        else $error("pop from empty mouse event FIFO");

endmodule

`default_nettype wire

/* rtl/mouse_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module mouse_tracker (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire                         pause,
    input  wire                         ev_avail,
    input  wire glue_pkg::mouse_delta_t head_dx,
    input  wire glue_pkg::mouse_delta_t head_dy,
    input  wire glue_pkg::mouse_btn_t   head_btn,
    output logic                        ev_pop,
    output glue_pkg::mouse_pos_t        mouse_x,
    output glue_pkg::mouse_pos_t        mouse_y,
    output glue_pkg::mouse_btn_t        mouse_btn
);
    import glue_pkg::*;

    mouse_pos_t step_x;
    mouse_pos_t step_y;

    // Drain one event per cycle unless held off
    assign ev_pop = ev_avail && !pause;

    // Widen the 9-bit deltas keeping their sign
    assign step_x = mouse_pos_t'(head_dx);
    assign step_y = mouse_pos_t'(head_dy);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mouse_x   <= '0;
            mouse_y   <= '0;
            mouse_btn <= '0;
        end else if (ev_pop) begin
            // Position wraps at 16 bits
            mouse_x   <= mouse_x + step_x;
            mouse_y   <= mouse_y + step_y;
            mouse_btn <= head_btn;
        end
    end

endmodule

`default_nettype wire

/* rtl/debug_probe.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_probe (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire glue_pkg::probe_sel_e probe_sel,
    input  wire glue_pkg::mouse_pos_t mouse_x,
    input  wire glue_pkg::mouse_pos_t mouse_y,
    input  wire glue_pkg::mouse_btn_t mouse_btn,
    input  wire                       mouse_overrun,
    input  wire                       crop_ok,
    input  wire glue_pkg::crop_off_t  crop_off,
    input  wire glue_pkg::crop_size_t crop_size,
    output logic [7:0]                target_info
);
    import glue_pkg::*;

    logic [7:0] probe_byte;

    always_comb begin
        case (probe_sel)
            PROBE_X_LO:    probe_byte = mouse_x[7:0];
            PROBE_X_HI:    probe_byte = mouse_x[15:8];
            PROBE_Y_LO:    probe_byte = mouse_y[7:0];
            PROBE_Y_HI:    probe_byte = mouse_y[15:8];
            PROBE_BTN:     probe_byte = {5'd0, mouse_btn};
            PROBE_CROP:    probe_byte = {crop_ok, 2'd0, crop_off};
            PROBE_SIZE_LO: probe_byte = crop_size[7:0];
            PROBE_SIZE_HI: probe_byte = {mouse_overrun, 3'd0, crop_size[11:8]};
            // Upper half of the selector range reads as zero
            default:       probe_byte = 8'd0;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            target_info <= 8'd0;
        end else begin
            target_info <= probe_byte;
        end
    end

endmodule

`default_nettype wire

/* rtl/platform_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module platform_glue (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire glue_pkg::status_t    status,
    input  wire [11:0]                hdmi_width,
    input  wire [11:0]                hdmi_height,
    input  wire                       force_scan2x,
    input  wire                       direct_video,
    input  wire [1:0]                 rotate,
    input  wire [24:0]                ps2_mouse,
    input  wire                       pause,
    input  wire glue_pkg::probe_sel_e probe_sel,
    output wire                       crop_ok,
    output glue_pkg::crop_off_t       crop_off,
    output glue_pkg::crop_size_t      crop_size,
    output glue_pkg::mouse_pos_t      mouse_x,
    output glue_pkg::mouse_pos_t      mouse_y,
    output glue_pkg::mouse_btn_t      mouse_btn,
    output wire                       mouse_overrun,
    output wire [7:0]                 target_info
);
    import glue_pkg::*;

    // Decoder to FIFO
    logic         ev_valid;
    mouse_delta_t ev_dx;
    mouse_delta_t ev_dy;
    mouse_btn_t   ev_btn;
    logic         credit_return;

    // FIFO to tracker
    logic         ev_avail;
    logic         ev_pop;
    mouse_delta_t head_dx;
    mouse_delta_t head_dy;
    mouse_btn_t   head_btn;

    crop_ctrl crop_ctrl_i (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .status       (status),
        .hdmi_width   (hdmi_width),
        .hdmi_height  (hdmi_height),
        .force_scan2x (force_scan2x),
        .direct_video (direct_video),
        .rotate       (rotate),
        .crop_ok      (crop_ok),
        .crop_off     (crop_off),
        .crop_size    (crop_size)
    );

    mouse_decoder mouse_decoder_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .ps2_mouse     (ps2_mouse),
        .credit_return (credit_return),
        .ev_valid      (ev_valid),
        .ev_dx         (ev_dx),
        .ev_dy         (ev_dy),
        .ev_btn        (ev_btn),
        .mouse_overrun (mouse_overrun)
    );

    mouse_event_buffer mouse_event_buffer_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .ev_valid      (ev_valid),
        .ev_dx         (ev_dx),
        .ev_dy         (ev_dy),
        .ev_btn        (ev_btn),
        .ev_pop        (ev_pop),
        .ev_avail      (ev_avail),
        .head_dx       (head_dx),
        .head_dy       (head_dy),
        .head_btn      (head_btn),
        .credit_return (credit_return)
    );

    mouse_tracker mouse_tracker_i (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .pause     (pause),
        .ev_avail  (ev_avail),
        .head_dx   (head_dx),
        .head_dy   (head_dy),
        .head_btn  (head_btn),
        .ev_pop    (ev_pop),
        .mouse_x   (mouse_x),
        .mouse_y   (mouse_y),
        .mouse_btn (mouse_btn)
    );

    debug_probe debug_probe_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .probe_sel     (probe_sel),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .mouse_btn     (mouse_btn),
        .mouse_overrun (mouse_overrun),
        .crop_ok       (crop_ok),
        .crop_off      (crop_off),
        .crop_size     (crop_size),
        .target_info   (target_info)
    );

endmodule

`default_nettype wire

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 32-bit linear congruential generator step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Common failure path for all compares
task automatic report_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    $display("mismatch %s got %h expected %h", name, got, expected);
    $display("SOME TESTS FAILED");
    $fatal(1);
endtask

task automatic check_crop_size(input string name, input glue_pkg::crop_size_t got,
                               input glue_pkg::crop_size_t expected);
    if (got !== expected) begin
        report_mismatch(name, 64'(got), 64'(expected));
    end
endtask

task automatic check_crop_off(input string name, input glue_pkg::crop_off_t got,
                              input glue_pkg::crop_off_t expected);
    // Compared as raw 5-bit patterns
    if (got !== expected) begin
        report_mismatch(name, 64'(unsigned'(got)), 64'(unsigned'(expected)));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        report_mismatch(name, 64'(got), 64'(expected));
    end
endtask

task automatic check_pos(input string name, input glue_pkg::mouse_pos_t got,
                         input glue_pkg::mouse_pos_t expected);
    if (got !== expected) begin
        report_mismatch(name, 64'(unsigned'(got)), 64'(unsigned'(expected)));
    end
endtask

task automatic check_byte(input string name, input logic [7:0] got,
                          input logic [7:0] expected);
    if (got !== expected) begin
        report_mismatch(name, 64'(got), 64'(expected));
    end
endtask

`endif

/* testbench/tb_platform_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_platform_glue;
    import glue_pkg::*;

    `include "tb_checks.svh"

    localparam int CROP_TRIALS = 200;
    localparam int MOUSE_PKTS  = 100;
    localparam int HELD_PKTS   = 6;
    // Reset, crop, mouse, back-pressure and probe phases at their longest
    localparam int TEST_CYCLES = 16 + CROP_TRIALS * 3 + MOUSE_PKTS * 5 + 10
                                 + 1 + HELD_PKTS * 5 + 10 + 10 + 16 * 2;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic        clk_sys;
    logic        reset;
    status_t     status;
    logic [11:0] hdmi_width;
    logic [11:0] hdmi_height;
    logic        force_scan2x;
    logic        direct_video;
    logic [1:0]  rotate;
    logic [24:0] ps2_mouse;
    logic        pause;
    probe_sel_e  probe_sel;
    logic        crop_ok;
    crop_off_t   crop_off;
    crop_size_t  crop_size;
    mouse_pos_t  mouse_x;
    mouse_pos_t  mouse_y;
    mouse_btn_t  mouse_btn;
    logic        mouse_overrun;
    logic [7:0]  target_info;

    logic [31:0] rng_state;
    int          cycles = 0;

    // Reference model state
    logic        exp_ok;
    crop_off_t   exp_off;
    crop_size_t  exp_size;
    mouse_pos_t  exp_x;
    mouse_pos_t  exp_y;
    mouse_btn_t  exp_btn;
    logic        exp_overrun;
    mouse_pos_t  held_x;
    mouse_pos_t  held_y;
    mouse_btn_t  held_btn;

    platform_glue platform_glue_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .status        (status),
        .hdmi_width    (hdmi_width),
        .hdmi_height   (hdmi_height),
        .force_scan2x  (force_scan2x),
        .direct_video  (direct_video),
        .rotate        (rotate),
        .ps2_mouse     (ps2_mouse),
        .pause         (pause),
        .probe_sel     (probe_sel),
        .crop_ok       (crop_ok),
        .crop_off      (crop_off),
        .crop_size     (crop_size),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .mouse_btn     (mouse_btn),
        .mouse_overrun (mouse_overrun),
        .target_info   (target_info)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    // Inputs change 2 ns after the edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #2;
        end
    endtask

    task automatic draw(output logic [31:0] value);
        rng_state = lcg_next(rng_state);
        value = rng_state;
    endtask

    task automatic apply_crop_case();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        draw(r0);
        draw(r1);
        draw(r2);
        status       = {r1, r0};
        hdmi_width   = r2[19:8];
        hdmi_height  = r2[27:16];
        force_scan2x = r2[28];
        direct_video = r2[29];
        rotate       = r2[13:12];
        if (r2[30]) begin
            hdmi_width  = 12'(CROP_HDMI_W);
            hdmi_height = 12'(CROP_HDMI_H);
        end
        // Half the cases open every gate so the crop really engages
        if (r2[31]) begin
            hdmi_width                   = 12'(CROP_HDMI_W);
            hdmi_height                  = 12'(CROP_HDMI_H);
            status[ST_FX_HI:ST_FX_LO]    = '0;
            status[ST_SCALE_LO +: 2]     = '0;
            force_scan2x                 = 1'b0;
            direct_video                 = 1'b0;
            rotate[0]                    = 1'b0;
        end
    endtask

    task automatic predict_crop();
        logic [3:0] vcopt;
        int         off;
        vcopt  = status[ST_VCOPT_LO +: 4];
        exp_ok = (hdmi_width == 12'(CROP_HDMI_W)) && (hdmi_height == 12'(CROP_HDMI_H))
                 && (status[ST_FX_HI:ST_FX_LO] == 3'd0) && !force_scan2x
                 && (status[ST_SCALE_LO +: 2] == 2'd0) && !direct_video && !rotate[0];
        off = 2 * int'(vcopt);
        if (vcopt >= VCOPT_SPLIT) begin
            off = off - VCOPT_WRAP;
        end
        exp_off  = crop_off_t'(off & 31);
        exp_size = (exp_ok && status[ST_CROP_EN]) ? crop_size_t'(CROP_LINES) : '0;
    endtask

    // Toggle the strobe with a fresh packet, then wait 2 to 5 cycles
    task automatic send_packet(input logic counted);
        logic [31:0] r;
        logic [31:0] g;
        logic [7:0]  flags;
        int          dx;
        int          dy;
        draw(r);
        draw(g);
        flags     = r[31:24];
        ps2_mouse = {~ps2_mouse[PKT_STROBE], r[15:8], r[23:16], flags};
        dx        = flags[4] ? int'(r[23:16]) - 256 : int'(r[23:16]);
        dy        = flags[5] ? int'(r[15:8]) - 256 : int'(r[15:8]);
        if (counted) begin
            exp_x   = exp_x + mouse_pos_t'(dx);
            exp_y   = exp_y + mouse_pos_t'(dy);
            exp_btn = flags[2:0];
        end
        step(2 + int'(g[31:30]));
    endtask

    task automatic check_mouse();
        check_pos("mouse_x", mouse_x, exp_x);
        check_pos("mouse_y", mouse_y, exp_y);
        check_byte("mouse_btn", {5'd0, mouse_btn}, {5'd0, exp_btn});
        check_bit("mouse_overrun", mouse_overrun, exp_overrun);
    endtask

    function automatic logic [7:0] probe_model(input int sel);
        case (sel)
            0:       return exp_x[7:0];
            1:       return exp_x[15:8];
            2:       return exp_y[7:0];
            3:       return exp_y[15:8];
            4:       return {5'd0, exp_btn};
            5:       return {exp_ok, 2'd0, exp_off};
            6:       return exp_size[7:0];
            7:       return {exp_overrun, 3'd0, exp_size[11:8]};
            default: return 8'd0;
        endcase
    endfunction

    initial begin
        reset        = 1'b1;
        status       = '0;
        // Croppable 1080p mode held through reset
        hdmi_width   = 12'(CROP_HDMI_W);
        hdmi_height  = 12'(CROP_HDMI_H);
        force_scan2x = 1'b0;
        direct_video = 1'b0;
        rotate       = '0;
        ps2_mouse    = '0;
        pause        = 1'b0;
        probe_sel    = PROBE_X_LO;
        rng_state    = 32'h00459018;
        exp_x        = '0;
        exp_y        = '0;
        exp_btn      = '0;
        exp_overrun  = 1'b0;
        step(16);
        reset = 1'b0;

        check_bit("crop_ok", crop_ok, 1'b0);
        check_mouse();
        check_byte("target_info", target_info, 8'd0);

        repeat (CROP_TRIALS) begin
            apply_crop_case();
            predict_crop();
            step(3);
            check_bit("crop_ok", crop_ok, exp_ok);
            check_crop_off("crop_off", crop_off, exp_off);
            check_crop_size("crop_size", crop_size, exp_size);
        end

        repeat (MOUSE_PKTS) begin
            send_packet(1'b1);
        end
        step(10);
        check_mouse();

        // Tracker stalled, so only the FIFO depth worth gets through
        held_x   = exp_x;
        held_y   = exp_y;
        held_btn = exp_btn;
        pause    = 1'b1;
        step(1);
        for (int i = 0; i < HELD_PKTS; i++) begin
            send_packet(i < MOUSE_DEPTH);
            if (i >= MOUSE_DEPTH) begin
                exp_overrun = 1'b1;
            end
        end
        step(10);
        check_pos("mouse_x", mouse_x, held_x);
        check_pos("mouse_y", mouse_y, held_y);
        check_byte("mouse_btn", {5'd0, mouse_btn}, {5'd0, held_btn});
        check_bit("mouse_overrun", mouse_overrun, exp_overrun);
        pause = 1'b0;
        step(10);
        check_mouse();

        for (int sel = 0; sel < 16; sel++) begin
            probe_sel = probe_sel_e'(4'(sel));
            step(2);
            check_byte("target_info", target_info, probe_model(sel));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
rtl/glue_pkg.sv
rtl/crop_ctrl.sv
rtl/mouse_decoder.sv
rtl/mouse_event_buffer.sv
rtl/mouse_tracker.sv
rtl/debug_probe.sv
rtl/platform_glue.sv
testbench/tb_platform_glue.sv
